// ==== rv_core.f ====
src/rv_isa_pkg.sv
src/rv_core_pkg.sv
src/rv_decode_if.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_regfile.sv
src/rv_core.sv
verif/rv_tb_memory.sv
verif/rv_core_tb.sv

// ==== src/rv_core.sv ====
/*
 * Multicycle RV32I core
 * Fetch, execute and memory sequencer with the PC and instruction
 * registers, valid/ready instruction and data ports, and the decode,
 * register file, execute and result blocks
 */
`timescale 1ns/10ps
`default_nettype none

module rv_core import rv_isa_pkg::*, rv_core_pkg::*; #(
	parameter word_t reset_vector = 32'h8000_0000,
	parameter int    num_regs     = 32
) (
	input  logic  clock,
	input  logic  reset,

	output word_t iaddr,
	input  word_t idata,
	output logic  ivalid,
	input  logic  iready,

	output word_t daddr,
	output word_t dwdata,
	input  word_t drdata,
	output strb_t dstrb,
	output logic  dwrite,
	output logic  dvalid,
	input  logic  dready
);

	core_state_e state;
	word_t       pc;
	word_t       instr;
	word_t       rs1_data;
	word_t       rs2_data;
	word_t       alu_result;
	word_t       next_pc;
	word_t       mem_addr;
	word_t       rd_wdata;
	logic        cmp_true;
	logic        rd_wen;
	logic        exec_phase;
	logic        mem_done;
	logic        is_mem;

	rv_decode_if dec_if ();

	assign iaddr  = pc;
	assign ivalid = (state == st_fetch) && !reset;
	assign dvalid = (state == st_memory) && !reset;
	assign dwrite = dvalid && (dec_if.instr_class == class_store);
	assign daddr  = {mem_addr[31:2], 2'b00}; // Lanes picked by dstrb

	assign exec_phase = (state == st_execute);
	assign mem_done   = dvalid && dready;
	assign is_mem     = (dec_if.instr_class == class_load) ||
		(dec_if.instr_class == class_store);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_fetch;
			pc    <= reset_vector;
		end else begin
			case (state)
				st_fetch: if (ivalid && iready) state <= st_execute;
				st_execute: begin
					if (is_mem) begin
						state <= st_memory;
					end else begin
						pc    <= next_pc;
						state <= st_fetch;
					end
				end
				st_memory: begin
					if (mem_done) begin
						pc    <= pc + 32'd4;
						state <= st_fetch;
					end
				end
				default: state <= st_fetch;
			endcase
		end
	end

	// Instruction register
	always_ff @(posedge clock) begin
		if (state == st_fetch && ivalid && iready) begin
			instr <= idata;
		end
	end

	rv_decode u_decode (
		.instr (instr),
		.dec   (dec_if.decode)
	);

	rv_regfile #(.num_regs(num_regs)) u_regfile (
		.clock   (clock),
		.reset   (reset),
		.ra_addr (dec_if.rs1),
		.rb_addr (dec_if.rs2),
		.wr_addr (dec_if.rd),
		.ra_data (rs1_data),
		.rb_data (rs2_data),
		.wr_data (rd_wdata),
		.wr_en   (rd_wen)
	);

	rv_execute u_execute (
		.dec        (dec_if.execute),
		.pc         (pc),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.alu_result (alu_result),
		.next_pc    (next_pc),
		.mem_addr   (mem_addr),
		.cmp_true   (cmp_true)
	);

	rv_result u_result (
		.dec        (dec_if.result),
		.exec_phase (exec_phase),
		.mem_done   (mem_done),
		.pc         (pc),
		.alu_result (alu_result),
		.mem_addr   (mem_addr),
		.rs2_data   (rs2_data),
		.drdata     (drdata),
		.cmp_true   (cmp_true),
		.rd_wen     (rd_wen),
		.rd_wdata   (rd_wdata),
		.dwdata     (dwdata),
		.dstrb      (dstrb)
	);

	// Data request held stable until accepted
	assert property (@(posedge clock) disable iff (reset)
		dvalid && !dready |=> dvalid && $stable(daddr) && $stable(dwdata) && $stable(dstrb))
		else $error("data request changed before dready");

	assert property (@(posedge clock) disable iff (reset)
		exec_phase |-> next_pc[1:0] == 2'b00)
		else $error("next_pc not word aligned: %h", next_pc);

endmodule

`default_nettype wire

// ==== src/rv_core_pkg.sv ====
/*
 * Core-level types
 * Data word, register index, byte strobe and the sequencer states
 */
`default_nettype none

package rv_core_pkg;

	typedef logic [31:0] word_t;    // Data or address word
	typedef logic [4:0]  reg_idx_t;
	typedef logic [3:0]  strb_t;    // One bit per byte lane

	// Multicycle sequencer, one instruction in flight
	typedef enum logic [1:0] {
		st_fetch,
		st_execute,
		st_memory
	} core_state_e;

endpackage

`default_nettype wire

// ==== src/rv_decode.sv ====
/*
 * RV32I instruction decoder
 * Classifies the opcode, extracts register fields, builds the I/S/B/J/U
 * immediates and picks the ALU and compare operations. Unknown opcodes
 * and FENCE decode to class none
 */
`timescale 1ns/10ps
`default_nettype none

module rv_decode import rv_isa_pkg::*, rv_core_pkg::*; (
	input  word_t       instr,
	rv_decode_if.decode dec
);

	opcode_t opcode;
	funct3_t funct3;
	word_t   imm_i;
	word_t   imm_s;
	word_t   imm_b;
	word_t   imm_j;
	word_t   imm_u;
	alu_op_e base_op;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};

	// Fixed field positions
	assign dec.rs1    = instr[19:15];
	assign dec.rs2    = instr[24:20];
	assign dec.rd     = instr[11:7];
	assign dec.funct3 = funct3;

	// ALU op shared by register and immediate forms
	always_comb begin
		case (funct3)
			f3_sll:     base_op = alu_sll;
			f3_xor:     base_op = alu_xor;
			f3_srl_sra: base_op = instr[30] ? alu_sra : alu_srl;
			f3_or:      base_op = alu_or;
			f3_and:     base_op = alu_and;
			default:    base_op = alu_add; // SLT forms use the comparator
		endcase
	end

	always_comb begin
		dec.instr_class = class_none;
		dec.alu_op      = alu_add;
		dec.cmp_op      = (funct3 == f3_sltu) ? cmp_ltu : cmp_lt;
		dec.op_a_sel    = opa_reg;
		dec.op_b_sel    = opb_imm;
		dec.imm         = imm_i;
		case (opcode)
			opc_lui: begin
				dec.instr_class = class_lui;
				dec.op_a_sel    = opa_zero;
				dec.imm         = imm_u;
			end
			opc_auipc: begin
				dec.instr_class = class_auipc;
				dec.op_a_sel    = opa_pc;
				dec.imm         = imm_u;
			end
			opc_jal: begin
				dec.instr_class = class_jal;
				dec.op_a_sel    = opa_pc;
				dec.imm         = imm_j;
			end
			opc_jalr: dec.instr_class = class_jalr; // rs1 + I-imm
			opc_branch: begin
				dec.instr_class = class_branch;
				dec.op_b_sel    = opb_reg;
				dec.imm         = imm_b;
				case (funct3[2:1])
					2'b00:   dec.cmp_op = cmp_eq;  // BEQ, BNE
					2'b10:   dec.cmp_op = cmp_lt;  // BLT, BGE
					default: dec.cmp_op = cmp_ltu;
				endcase
			end
			opc_load:  dec.instr_class = class_load;
			opc_store: begin
				dec.instr_class = class_store;
				dec.imm         = imm_s;
			end
			opc_op_imm: begin
				dec.instr_class = class_alu;
				dec.alu_op      = base_op; // No SUBI
			end
			opc_op: begin
				dec.instr_class = class_alu;
				dec.op_b_sel    = opb_reg;
				dec.alu_op      = (funct3 == f3_add_sub && instr[30]) ? alu_sub : base_op;
			end
			opc_fence: dec.instr_class = class_none; // Single-issue, nothing to order
			default:   dec.instr_class = class_none;
		endcase
	end

	assign dec.is_slt = (opcode == opc_op || opcode == opc_op_imm) &&
		(funct3 == f3_slt || funct3 == f3_sltu);

endmodule

`default_nettype wire

// ==== src/rv_decode_if.sv ====
/*
 * Decoded instruction control
 * Written by the decoder, read by execute and result. Fields follow the
 * instruction register with no handshake
 */
`timescale 1ns/10ps
`default_nettype none

interface rv_decode_if import rv_isa_pkg::*, rv_core_pkg::*; ();

	instr_class_e instr_class;
	alu_op_e      alu_op;
	cmp_op_e      cmp_op;
	opa_sel_e     op_a_sel;
	opb_sel_e     op_b_sel;
	word_t        imm;          // Sign-extended, format per class
	reg_idx_t     rs1;
	reg_idx_t     rs2;
	reg_idx_t     rd;
	funct3_t      funct3;
	logic         is_slt;       // SLT, SLTU, SLTI, SLTIU

	modport decode (output instr_class, alu_op, cmp_op, op_a_sel, op_b_sel,
		imm, rs1, rs2, rd, funct3, is_slt);

	modport execute (input instr_class, alu_op, cmp_op, op_a_sel, op_b_sel,
		imm, funct3);

	modport result (input instr_class, rd, funct3, is_slt);

endinterface

`default_nettype wire

// ==== src/rv_execute.sv ====
/*
 * Execute stage
 * Operand selection, adder/shifter ALU, comparator, branch resolution,
 * next-PC selection and the data address
 */
`timescale 1ns/10ps
`default_nettype none

module rv_execute import rv_isa_pkg::*, rv_core_pkg::*; (
	rv_decode_if.execute dec,
	input  word_t        pc,
	input  word_t        rs1_data,
	input  word_t        rs2_data,
	output word_t        alu_result,
	output word_t        next_pc,
	output word_t        mem_addr,
	output logic         cmp_true
);

	word_t      op_a;
	word_t      op_b;
	logic [4:0] shamt;
	logic       cmp_raw;
	word_t      pc_plus4;
	word_t      pc_target;

	always_comb begin
		case (dec.op_a_sel)
			opa_pc:   op_a = pc;
			opa_zero: op_a = '0;   // LUI
			default:  op_a = rs1_data;
		endcase
	end

	assign op_b  = (dec.op_b_sel == opb_imm) ? dec.imm : rs2_data;
	assign shamt = op_b[4:0];

	always_comb begin
		case (dec.alu_op)
			alu_sub: alu_result = op_a - op_b;
			alu_sll: alu_result = op_a << shamt;
			alu_srl: alu_result = op_a >> shamt;
			alu_sra: alu_result = $signed(op_a) >>> shamt;
			alu_xor: alu_result = op_a ^ op_b;
			alu_or:  alu_result = op_a | op_b;
			alu_and: alu_result = op_a & op_b;
			default: alu_result = op_a + op_b;
		endcase
	end

	// Comparator, rs1 against rs2 or immediate
	always_comb begin
		case (dec.cmp_op)
			cmp_eq:  cmp_raw = (op_a == op_b);
			cmp_lt:  cmp_raw = ($signed(op_a) < $signed(op_b));
			default: cmp_raw = (op_a < op_b);
		endcase
	end

	// BNE, BGE, BGEU take the inverse
	assign cmp_true = (dec.instr_class == class_branch) ? (cmp_raw ^ dec.funct3[0]) : cmp_raw;

	assign pc_plus4  = pc + 32'd4;
	assign pc_target = pc + dec.imm; // Branch and JAL target

	always_comb begin
		if (dec.instr_class == class_jal ||
				(dec.instr_class == class_branch && cmp_true)) begin
			next_pc = pc_target;
		end else if (dec.instr_class == class_jalr) begin
			next_pc = {alu_result[31:1], 1'b0};
		end else begin
			next_pc = pc_plus4;
		end
	end

	// Byte address; the core aligns it for the bus
	assign mem_addr = rs1_data + dec.imm;

endmodule

`default_nettype wire

// ==== src/rv_isa_pkg.sv ====
/*
 * RV32I instruction set encodings
 * Major opcodes, funct3 codes, and the operation, operand-select and
 * instruction-class enums shared by the decoder and the datapath
 */
`default_nettype none

package rv_isa_pkg;

	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;

	localparam opcode_t opc_lui    = 7'b0110111;
	localparam opcode_t opc_auipc  = 7'b0010111;
	localparam opcode_t opc_jal    = 7'b1101111;
	localparam opcode_t opc_jalr   = 7'b1100111;
	localparam opcode_t opc_branch = 7'b1100011;
	localparam opcode_t opc_load   = 7'b0000011;
	localparam opcode_t opc_store  = 7'b0100011;
	localparam opcode_t opc_op_imm = 7'b0010011;
	localparam opcode_t opc_op     = 7'b0110011;
	localparam opcode_t opc_fence  = 7'b0001111;

	// Arithmetic funct3
	localparam funct3_t f3_add_sub = 3'b000;
	localparam funct3_t f3_sll     = 3'b001;
	localparam funct3_t f3_slt     = 3'b010;
	localparam funct3_t f3_sltu    = 3'b011;
	localparam funct3_t f3_xor     = 3'b100;
	localparam funct3_t f3_srl_sra = 3'b101;
	localparam funct3_t f3_or      = 3'b110;
	localparam funct3_t f3_and     = 3'b111;

	// Access size, low two bits of load/store funct3
	localparam funct3_t f3_byte    = 3'b000;
	localparam funct3_t f3_half    = 3'b001;

	typedef enum logic [2:0] {alu_add, alu_sub, alu_sll, alu_srl, alu_sra,
		alu_xor, alu_or, alu_and} alu_op_e;
	typedef enum logic [1:0] {cmp_eq, cmp_lt, cmp_ltu} cmp_op_e;
	typedef enum logic [3:0] {class_lui, class_auipc, class_jal, class_jalr,
		class_branch, class_load, class_store, class_alu, class_none} instr_class_e;
	typedef enum logic [1:0] {opa_reg, opa_pc, opa_zero} opa_sel_e;
	typedef enum logic {opb_reg, opb_imm} opb_sel_e;

endpackage

`default_nettype wire

// ==== src/rv_regfile.sv ====
/*
 * Register file
 * Two combinational read ports and one write port, register zero reads
 * as zero. Sized for RV32I or RV32E
 */
`timescale 1ns/10ps
`default_nettype none

module rv_regfile import rv_core_pkg::*; #(
	parameter int num_regs = 32
) (
	input  logic     clock,
	input  logic     reset,
	input  reg_idx_t ra_addr,
	input  reg_idx_t rb_addr,
	input  reg_idx_t wr_addr,
	output word_t    ra_data,
	output word_t    rb_data,
	input  word_t    wr_data,
	input  logic     wr_en
);

	localparam int idx_bits = $clog2(num_regs);

	logic [idx_bits-1:0] ra_idx;
	logic [idx_bits-1:0] rb_idx;
	logic [idx_bits-1:0] wr_idx;
	word_t               regs [num_regs];

	// Upper index bit dropped for a 16-entry file
	assign ra_idx = ra_addr[idx_bits-1:0];
	assign rb_idx = rb_addr[idx_bits-1:0];
	assign wr_idx = wr_addr[idx_bits-1:0];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign ra_data = (ra_idx == '0) ? '0 : regs[ra_idx];
	assign rb_data = (rb_idx == '0) ? '0 : regs[rb_idx];

endmodule

`default_nettype wire

// ==== src/rv_result.sv ====
/*
 * Result stage
 * Store lane steering, load lane extraction with sign or zero extension,
 * write-back data select and register write enable
 */
`timescale 1ns/10ps
`default_nettype none

module rv_result import rv_isa_pkg::*, rv_core_pkg::*; (
	rv_decode_if.result dec,
	input  logic        exec_phase,
	input  logic        mem_done,
	input  word_t       pc,
	input  word_t       alu_result,
	input  word_t       mem_addr,
	input  word_t       rs2_data,
	input  word_t       drdata,
	input  logic        cmp_true,
	output logic        rd_wen,
	output word_t       rd_wdata,
	output word_t       dwdata,
	output strb_t       dstrb
);

	funct3_t size;
	word_t   byte_lane;
	word_t   half_lane;
	word_t   load_data;
	logic    exec_writes;

	assign size = {1'b0, dec.funct3[1:0]};

	// Replicate narrow store data across lanes
	always_comb begin
		case (size)
			f3_byte: begin
				dwdata = {4{rs2_data[7:0]}};
				dstrb  = strb_t'(4'b0001 << mem_addr[1:0]);
			end
			f3_half: begin
				dwdata = {2{rs2_data[15:0]}};
				dstrb  = mem_addr[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				dwdata = rs2_data;
				dstrb  = 4'b1111;
			end
		endcase
	end

	assign byte_lane = drdata >> {mem_addr[1:0], 3'b000};
	assign half_lane = drdata >> {mem_addr[1], 4'b0000};

	always_comb begin
		case (size)
			f3_byte: load_data = dec.funct3[2] ? {24'h0, byte_lane[7:0]} :
				{{24{byte_lane[7]}}, byte_lane[7:0]};
			f3_half: load_data = dec.funct3[2] ? {16'h0, half_lane[15:0]} :
				{{16{half_lane[15]}}, half_lane[15:0]};
			default: load_data = drdata;
		endcase
	end

	always_comb begin
		if (dec.instr_class == class_jal || dec.instr_class == class_jalr) begin
			rd_wdata = pc + 32'd4; // Link
		end else if (dec.is_slt) begin
			rd_wdata = {31'h0, cmp_true};
		end else if (dec.instr_class == class_load) begin
			rd_wdata = load_data;
		end else begin
			rd_wdata = alu_result;
		end
	end

	assign exec_writes = dec.instr_class inside {class_lui, class_auipc, class_jal,
		class_jalr, class_alu};

	assign rd_wen = ((exec_phase && exec_writes) || (mem_done && dec.instr_class == class_load))
		&& (dec.rd != 5'd0);

endmodule

`default_nettype wire

// ==== verif/rv_core_tb.sv ====
/*
 * Testbench for the multicycle RV32I core
 * Loads a program that stores its results, checks every store against
 * a table built from the ISA rules, and watches the port handshakes
 */
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb import rv_isa_pkg::*; ();

	localparam logic [31:0] reset_vector = 32'h8000_0000;

	logic        clock;
	logic        reset;
	logic [31:0] iaddr;
	logic [31:0] idata;
	logic [31:0] daddr;
	logic [31:0] dwdata;
	logic [31:0] drdata;
	logic [3:0]  dstrb;
	logic        ivalid;
	logic        iready;
	logic        dwrite;
	logic        dvalid;
	logic        dready;

	logic [31:0] exp_addr [32];
	logic [31:0] exp_data [32];
	logic [3:0]  exp_strb [32];
	int          test_last [6];
	int          test_errs [7];
	int          n_exp;
	int          st_idx;
	int          n_instr;
	int          cycles;
	int          limit;
	int          checks;
	int          errors;
	bit          fetched;

	rv_core #(.reset_vector(reset_vector), .num_regs(32)) uut (.*);
	rv_tb_memory mem (.*);

	always #5 clock = ~clock;

	function automatic logic [31:0] enc_i(logic [11:0] imm, int rs1, logic [2:0] f3,
			int rd, logic [6:0] op);
		return {imm, 5'(rs1), f3, 5'(rd), op};
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, int rs2, int rs1,
			logic [2:0] f3, int rd);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc_op};
	endfunction

	function automatic logic [31:0] enc_s(logic [11:0] imm, int rs2, int rs1, logic [2:0] f3);
		return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], opc_store};
	endfunction

	function automatic logic [31:0] enc_b(logic [12:0] imm, int rs2, int rs1, logic [2:0] f3);
		return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], opc_branch};
	endfunction

	function automatic logic [31:0] enc_j(logic [20:0] imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), opc_jal};
	endfunction

	function automatic string test_name(int t);
		case (t)
			1: return "reset";
			2: return "arithmetic";
			3: return "sub-word stores";
			4: return "loads";
			5: return "control flow";
			default: return "back-pressure";
		endcase
	endfunction

	function automatic logic [31:0] pc_now();
		return reset_vector + 32'(n_instr * 4);
	endfunction

	task automatic emit(logic [31:0] w);
		mem.rom[n_instr] = w;
		n_instr++;
	endtask

	task automatic expect_store(logic [31:0] a, logic [31:0] d, logic [3:0] s);
		exp_addr[n_exp] = a;
		exp_data[n_exp] = d;
		exp_strb[n_exp] = s;
		n_exp++;
	endtask

	task automatic note_error(int t, string msg);
		$display("%s", msg);
		errors++;
		test_errs[t]++;
	endtask

	task automatic finish_test(int t);
		$display("test %0d %s: %0d error(s)", t, test_name(t), test_errs[t]);
	endtask

	task automatic load_program();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] s6;
		logic [31:0] w;
		logic [31:0] p;
		a = 32'd100;
		b = 32'hFFFF_FFF9;
		w = 32'h80F1_9F82;
		mem.ram[32] = w; // Byte address 0x180
		emit(enc_i(12'h100, 0, 3'b000, 10, opc_op_imm));
		emit(enc_i(12'd100, 0, 3'b000, 1, opc_op_imm));
		emit(enc_i(12'hFF9, 0, 3'b000, 2, opc_op_imm));
		emit(enc_r(7'h00, 2, 1, 3'b000, 3));       // add
		emit(enc_s(12'h000, 3, 10, 3'b010));
		expect_store(32'h100, a + b, 4'hF);
		emit(enc_r(7'h20, 2, 1, 3'b000, 4));       // sub
		emit(enc_s(12'h004, 4, 10, 3'b010));
		expect_store(32'h104, a - b, 4'hF);
		emit(enc_r(7'h00, 2, 1, 3'b100, 5));       // xor
		emit(enc_s(12'h008, 5, 10, 3'b010));
		expect_store(32'h108, a ^ b, 4'hF);
		s6 = b << 4;
		emit(enc_i(12'h004, 2, 3'b001, 6, opc_op_imm));
		emit(enc_i(12'h402, 6, 3'b101, 7, opc_op_imm)); // srai
		emit(enc_s(12'h00C, 7, 10, 3'b010));
		expect_store(32'h10C, 32'($signed(s6) >>> 2), 4'hF);
		emit(enc_i(12'h01C, 6, 3'b101, 8, opc_op_imm)); // srli
		emit(enc_s(12'h010, 8, 10, 3'b010));
		expect_store(32'h110, s6 >> 28, 4'hF);
		emit(enc_i(12'h0F0, 2, 3'b111, 9, opc_op_imm));
		emit(enc_s(12'h014, 9, 10, 3'b010));
		expect_store(32'h114, b & 32'h0F0, 4'hF);
		emit(enc_r(7'h00, 1, 2, 3'b010, 11));      // slt
		emit(enc_s(12'h018, 11, 10, 3'b010));
		expect_store(32'h118, 32'($signed(b) < $signed(a)), 4'hF);
		emit(enc_r(7'h00, 1, 2, 3'b011, 12));      // sltu
		emit(enc_s(12'h01C, 12, 10, 3'b010));
		expect_store(32'h11C, 32'(b < a), 4'hF);
		emit(enc_i(12'hFFF, 1, 3'b010, 13, opc_op_imm));
		emit(enc_s(12'h020, 13, 10, 3'b010));
		expect_store(32'h120, 32'($signed(a) < -1), 4'hF);
		emit(enc_i(12'hFFF, 1, 3'b011, 14, opc_op_imm));
		emit(enc_s(12'h024, 14, 10, 3'b010));
		expect_store(32'h124, 32'(a < 32'hFFFF_FFFF), 4'hF);
		emit({20'h12345, 5'd16, opc_lui});
		emit(enc_s(12'h028, 16, 10, 3'b010));
		expect_store(32'h128, 32'h1234_5000, 4'hF);
		p = pc_now();
		emit({20'h00001, 5'd17, opc_auipc});
		emit(enc_s(12'h02C, 17, 10, 3'b010));
		expect_store(32'h12C, p + 32'h1000, 4'hF);
		emit(enc_i(12'd5, 1, 3'b000, 0, opc_op_imm)); // Write to x0
		emit(enc_s(12'h030, 0, 10, 3'b010));
		expect_store(32'h130, 32'h0, 4'hF);
		test_last[2] = n_exp - 1;
		emit({20'hCAFEB, 5'd18, opc_lui});
		emit(enc_i(12'h6D5, 18, 3'b000, 18, opc_op_imm));
		emit(enc_s(12'h041, 18, 10, 3'b000));
		expect_store(32'h140, {4{8'hD5}}, 4'b0010);
		emit(enc_s(12'h046, 18, 10, 3'b001));
		expect_store(32'h144, {2{16'hB6D5}}, 4'b1100);
		emit(enc_s(12'h04B, 18, 10, 3'b000));
		expect_store(32'h148, {4{8'hD5}}, 4'b1000);
		test_last[3] = n_exp - 1;
		emit(enc_i(12'h080, 10, 3'b000, 19, opc_load)); // lb lane 0
		emit(enc_s(12'h0C0, 19, 10, 3'b010));
		expect_store(32'h1C0, {{24{w[7]}}, w[7:0]}, 4'hF);
		emit(enc_i(12'h083, 10, 3'b100, 20, opc_load)); // lbu lane 3
		emit(enc_s(12'h0C4, 20, 10, 3'b010));
		expect_store(32'h1C4, {24'h0, w[31:24]}, 4'hF);
		emit(enc_i(12'h082, 10, 3'b001, 21, opc_load)); // lh upper half
		emit(enc_s(12'h0C8, 21, 10, 3'b010));
		expect_store(32'h1C8, {{16{w[31]}}, w[31:16]}, 4'hF);
		emit(enc_i(12'h080, 10, 3'b101, 22, opc_load)); // lhu lower half
		emit(enc_s(12'h0CC, 22, 10, 3'b010));
		expect_store(32'h1CC, {16'h0, w[15:0]}, 4'hF);
		emit(enc_i(12'h080, 10, 3'b010, 23, opc_load));
		emit(enc_s(12'h0D0, 23, 10, 3'b010));
		expect_store(32'h1D0, w, 4'hF);
		test_last[4] = n_exp - 1;
		// Taken branches skip a poison store to 0x1F8
		emit(enc_b(13'd8, 1, 1, 3'b000));
		emit(enc_s(12'h0F8, 0, 10, 3'b010));
		emit(enc_b(13'd8, 1, 1, 3'b001));
		emit(enc_s(12'h0E0, 1, 10, 3'b010));
		expect_store(32'h1E0, a, 4'hF);
		emit(enc_b(13'd8, 1, 2, 3'b100));
		emit(enc_s(12'h0F8, 0, 10, 3'b010));
		emit(enc_b(13'd8, 1, 2, 3'b101));
		emit(enc_s(12'h0E4, 2, 10, 3'b010));
		expect_store(32'h1E4, b, 4'hF);
		emit(enc_b(13'd8, 2, 1, 3'b110));
		emit(enc_s(12'h0F8, 0, 10, 3'b010));
		emit(enc_b(13'd8, 2, 1, 3'b111));
		emit(enc_s(12'h0E8, 3, 10, 3'b010));
		expect_store(32'h1E8, a + b, 4'hF);
		p = pc_now();
		emit(enc_j(21'd8, 25));
		emit(enc_s(12'h0F8, 0, 10, 3'b010));
		emit(enc_s(12'h0EC, 25, 10, 3'b010));
		expect_store(32'h1EC, p + 4, 4'hF);
		p = pc_now();
		emit({20'h0, 5'd26, opc_auipc});
		emit(enc_i(12'd12, 26, 3'b000, 27, opc_jalr));
		emit(enc_s(12'h0F8, 0, 10, 3'b010));
		emit(enc_s(12'h0F0, 27, 10, 3'b010));
		expect_store(32'h1F0, p + 8, 4'hF);
		test_last[5] = n_exp - 1;
		emit(enc_j(21'd0, 0)); // Park here
	endtask

	function automatic int test_of(int idx);
		for (int t = 2; t <= 5; t++) begin
			if (idx <= test_last[t]) return t;
		end
		return 5;
	endfunction

	// Store and first-fetch checks
	always @(posedge clock) begin
		if (!reset && ivalid && iready && !fetched) begin
			fetched = 1'b1;
			checks++;
			assert (iaddr == reset_vector) else
				note_error(1, $sformatf("FAIL iaddr: got %h expected %h", iaddr, reset_vector));
			finish_test(1);
		end
		if (!reset && dvalid && dready && dwrite) begin
			if (st_idx >= n_exp) begin
				note_error(5, $sformatf("unexpected store to address %h", daddr));
			end else begin
				checks++;
				assert (daddr == exp_addr[st_idx]) else note_error(test_of(st_idx),
					$sformatf("FAIL daddr: got %h expected %h", daddr, exp_addr[st_idx]));
				assert (dwdata == exp_data[st_idx]) else note_error(test_of(st_idx),
					$sformatf("FAIL dwdata: got %h expected %h", dwdata, exp_data[st_idx]));
				assert (dstrb == exp_strb[st_idx]) else note_error(test_of(st_idx),
					$sformatf("FAIL dstrb: got %h expected %h", dstrb, exp_strb[st_idx]));
				if (st_idx == test_last[test_of(st_idx)]) finish_test(test_of(st_idx));
				st_idx++;
			end
		end
	end

	assert property (@(posedge clock) reset |-> !ivalid && !dvalid)
		else note_error(1, "request raised during reset");
	assert property (@(posedge clock) disable iff (reset) !(ivalid && dvalid))
		else note_error(6, "instruction and data requests high together");
	assert property (@(posedge clock) disable iff (reset) dvalid && !dready |=>
		dvalid && $stable(daddr) && $stable(dwdata) && $stable(dstrb) && $stable(dwrite))
		else note_error(6, "data request changed while waiting for dready");
	assert property (@(posedge clock) disable iff (reset) ivalid && !iready |=>
		ivalid && $stable(iaddr))
		else note_error(6, "fetch address changed while waiting for iready");

	// Run limit from the program length
	always @(posedge clock) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout after %0d cycles, %0d of %0d stores seen", cycles, st_idx, n_exp);
			$display("Test failures found");
			$finish;
		end
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		n_exp = 0;
		st_idx = 0;
		n_instr = 0;
		cycles = 0;
		limit = 0;
		checks = 0;
		errors = 0;
		fetched = 1'b0;
		@(negedge clock);
		load_program();
		limit = 16 + n_instr * 10 + 50;
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		wait (st_idx == n_exp);
		repeat (30) @(posedge clock); // Catch any stray store
		finish_test(6);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/rv_tb_memory.sv ====
/*
 * Testbench memory model
 * Instruction ROM and byte-strobed data RAM on valid/ready ports, with
 * pseudo-random ready delays of 0 to 3 cycles
 */
`timescale 1ns/10ps
`default_nettype none

module rv_tb_memory (
	input  logic        clock,
	input  logic [31:0] iaddr,
	output logic [31:0] idata,
	input  logic        ivalid,
	output logic        iready,
	input  logic [31:0] daddr,
	input  logic [31:0] dwdata,
	output logic [31:0] drdata,
	input  logic [3:0]  dstrb,
	input  logic        dwrite,
	input  logic        dvalid,
	output logic        dready
);

	logic [31:0] rom [128];
	logic [31:0] ram [64];
	logic [31:0] rng;
	int          iwait;
	int          dwait;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	initial begin
		rng    = 32'he632;
		iwait  = 0;
		dwait  = 0;
		iready = 1'b0;
		dready = 1'b0;
		for (int i = 0; i < 128; i++) begin
			rom[i] = 32'h0000_0013; // NOP
		end
		for (int i = 0; i < 64; i++) begin
			ram[i] = {8'(i), 8'(~i), 8'(i * 3 + 8'h40), 8'(i ^ 8'h5a)};
		end
	end

	assign idata  = rom[iaddr[8:2]];
	assign drdata = ram[daddr[7:2]];

	// Ready follows a random wait once a request is seen
	always @(negedge clock) begin
		if (ivalid) begin
			if (iwait == 0) iready <= 1'b1;
			else iwait = iwait - 1;
		end else begin
			iready <= 1'b0;
			rng = xorshift(rng);
			iwait = rng[1:0];
		end
		if (dvalid) begin
			if (dwait == 0) dready <= 1'b1;
			else dwait = dwait - 1;
		end else begin
			dready <= 1'b0;
			rng = xorshift(rng);
			dwait = rng[3:2];
		end
	end

	always @(posedge clock) begin
		if (dvalid && dready && dwrite) begin
			for (int b = 0; b < 4; b++) begin
				if (dstrb[b]) ram[daddr[7:2]][b*8 +: 8] <= dwdata[b*8 +: 8];
			end
		end
	end

endmodule

`default_nettype wire
